// File: common/st_glue_pkg.sv
package st_glue_pkg;

  // audio path
  localparam int audio_in_w = 15;   // chipset mix, signed
  localparam int audio_w    = 16;   // output to dac/hdmi

  // keyboard matrix as seen by the ikbd side
  localparam int kbd_rows = 15;
  localparam int kbd_cols = 8;

  // mouse and joystick codes
  localparam int mouse_w   = 6;     // 4 directions + 2 buttons
  localparam int hid_joy_w = 8;     // 4 directions + 4 buttons from usb
  localparam int joy1_w    = 5;     // st joystick port takes one fire button
  localparam int io_w      = 8;     // generic fpga pins, db9 wired here

  // ram side
  localparam int ram_addr_w = 23;   // cpu word address [23:1], bit 23 selects bus
  localparam int ram_word_w = 22;   // sdram word address [22:1]
  localparam int scramble_w = 2;    // xor'ed into address bits 4:3

  // rom lives in spi flash
  localparam int flash_addr_w = 22;
  localparam int rom_low_w    = 17; // 256k window, word address [17:1]

  // sd card side
  localparam int img_size_w = 64;
  localparam int lba_w      = 32;
  localparam int sd_byte_w  = 8;
  localparam int sd_drives  = 2;    // request bits per requester

  // give the mcu two seconds at 32 MHz to mount a default image
  localparam int unsigned sd_wait_cycles = 64_000_000;

  typedef enum logic [1:0] {
    chip_st      = 2'd0,
    chip_mega_st = 2'd1,            // adds blitter
    chip_ste     = 2'd2
  } chipset_t;

  typedef enum logic [1:0] {
    port_usb       = 2'd0,          // hid mouse, db9 used as joystick
    port_db9_atari = 2'd1,
    port_db9_amiga = 2'd2,
    port_none      = 2'd3
  } mouse_port_t;

  typedef enum logic [1:0] {
    vol_mute    = 2'd0,
    vol_quarter = 2'd1,
    vol_half    = 2'd2,
    vol_full    = 2'd3
  } volume_t;

  typedef enum logic {
    owner_floppy = 1'b0,
    owner_acsi   = 1'b1
  } sd_owner_t;

  // one byte per matrix row, row 0 at the low end
  typedef logic [kbd_rows-1:0][kbd_cols-1:0] kbd_matrix_t;

endpackage

// File: sys_control/sys_control.sv
`timescale 1ns/1ps

module sys_control #(
  parameter int unsigned wait_cycles = st_glue_pkg::sd_wait_cycles
) (
  input  logic                                  clk32,
  input  logic                                  rst_n,
  input  logic                                  btn_reset,
  input  logic                                  sys_reset_req,
  input  logic                                  coldboot,     // rising edge = new cold boot
  input  logic                                  ram_ready,
  input  logic                                  flash_ready,
  input  logic [st_glue_pkg::img_size_w-1:0]    img_size,     // nonzero once sd is mounted
  input  st_glue_pkg::chipset_t                 chipset,
  input  logic                                  tos_slot,     // primary/secondary tos
  input  logic [st_glue_pkg::rom_low_w:1]       rom_addr,
  input  logic [st_glue_pkg::ram_addr_w:1]      ram_addr,
  input  logic                                  ram_ras_n,
  output logic                                  st_resb,      // st reset, low active
  output logic [st_glue_pkg::ram_word_w:1]      ram_word,
  output logic                                  ram_cs,
  output logic [st_glue_pkg::flash_addr_w-1:0]  rom_flash_addr
);
  import st_glue_pkg::*;

  logic [31:0]          sd_wait;    // boot timeout counter
  logic                 sd_ready;
  logic                 coldboot_d;
  logic [scramble_w-1:0] scramble;

  // wait for an image to be mounted, but not forever
  always_ff @(posedge clk32) begin
    if (!rst_n) begin
      sd_wait  <= '0;
      sd_ready <= 1'b0;
    end else if (!sd_ready) begin
      if (img_size != '0) begin
        sd_ready <= 1'b1;               // card up and image known
      end
      if (sd_wait < 32'(wait_cycles)) begin
        sd_wait <= sd_wait + 32'd1;
      end else begin
        sd_ready <= 1'b1;               // timed out, boot without image
      end
    end
  end

  assign st_resb = sd_ready && ram_ready && flash_ready &&
                   !btn_reset && !sys_reset_req;

  // each coldboot edge moves the ram contents to other addresses
  always_ff @(posedge clk32) begin
    if (!rst_n) begin
      coldboot_d <= 1'b0;
      scramble   <= '0;
    end else begin
      coldboot_d <= coldboot;
      if (coldboot && !coldboot_d) begin
        scramble <= scramble + scramble_w'(1);
      end
    end
  end

  // scramble only address lines 4:3, enough to make old ram look garbage
  assign ram_word = {ram_addr[ram_word_w:5], ram_addr[4:3] ^ scramble, ram_addr[2:1]};

  // bit 23 is the other bus, not sdram
  assign ram_cs = !ram_ras_n && !ram_addr[ram_addr_w];

  // tos sits at $100000 (st) or $140000 (ste), the secondary slots above that
  assign rom_flash_addr = {3'b001, tos_slot, chipset >= chip_ste, rom_addr};

endmodule

// File: sd_req_router/sd_req_router.sv
`timescale 1ns/1ps

module sd_req_router (
  input  logic                                  clk32,
  input  logic                                  rst_n,
  input  logic [st_glue_pkg::sd_drives-1:0]     fdc_rd,       // floppy sector read
  input  logic [st_glue_pkg::sd_drives-1:0]     fdc_wr,       // floppy sector write
  input  logic [st_glue_pkg::lba_w-1:0]         fdc_lba,
  input  logic [st_glue_pkg::sd_byte_w-1:0]     fdc_wr_byte,
  input  logic [st_glue_pkg::sd_drives-1:0]     acsi_rd,      // hard disk sector read
  input  logic [st_glue_pkg::sd_drives-1:0]     acsi_wr,
  input  logic [st_glue_pkg::lba_w-1:0]         acsi_lba,
  input  logic [st_glue_pkg::sd_byte_w-1:0]     acsi_wr_byte,
  output logic [2*st_glue_pkg::sd_drives-1:0]   sd_rstart,    // to sd card controller
  output logic [2*st_glue_pkg::sd_drives-1:0]   sd_wstart,
  output logic [st_glue_pkg::lba_w-1:0]         sd_sector,
  output logic [st_glue_pkg::sd_byte_w-1:0]     sd_inbyte
);
  import st_glue_pkg::*;

  logic      fdc_req;
  logic      acsi_req;
  sd_owner_t owner_q;     // who had the card last
  sd_owner_t owner;       // effective this cycle

  // controller slots 0..1 are floppy, 2..3 acsi
  assign sd_rstart = {acsi_rd, fdc_rd};
  assign sd_wstart = {acsi_wr, fdc_wr};

  assign fdc_req  = |{fdc_rd, fdc_wr};
  assign acsi_req = |{acsi_rd, acsi_wr};

  // remember the last requester, data keeps flowing after start drops
  always_ff @(posedge clk32) begin
    if (!rst_n) begin
      owner_q <= owner_floppy;
    end else if (fdc_req) begin
      owner_q <= owner_floppy;          // floppy wins a tie
    end else if (acsi_req) begin
      owner_q <= owner_acsi;
    end
  end

  // a live acsi request takes the card at once
  assign owner = acsi_req ? owner_acsi : owner_q;

  always_comb begin
    case (owner)
      owner_acsi: begin
        sd_sector = acsi_lba;
        sd_inbyte = acsi_wr_byte;
      end
      default: begin
        sd_sector = fdc_lba;
        sd_inbyte = fdc_wr_byte;
      end
    endcase
  end

endmodule

// File: rtl/input_mux.sv
`timescale 1ns/1ps

module input_mux (
  input  logic [st_glue_pkg::io_w-1:0]       io,             // db9 pins, active low
  input  st_glue_pkg::mouse_port_t           port_mouse,
  input  logic [st_glue_pkg::mouse_w-1:0]    hid_mouse,
  input  logic [st_glue_pkg::hid_joy_w-1:0]  hid_joy,
  input  st_glue_pkg::kbd_matrix_t           keyboard,       // key state per row, 0 = pressed
  input  logic [st_glue_pkg::kbd_rows-1:0]   kbd_matrix_out, // row select from ikbd, low active
  output logic [st_glue_pkg::mouse_w-1:0]    joy0,           // st mouse port
  output logic [st_glue_pkg::joy1_w-1:0]     joy1,           // st joystick port
  output logic [st_glue_pkg::mouse_w-1:0]    db9_joy,
  output logic [st_glue_pkg::kbd_cols-1:0]   kbd_matrix_in   // column read back
);
  import st_glue_pkg::*;

  logic [mouse_w-1:0] db9_atari;
  logic [mouse_w-1:0] db9_amiga;

  // pins are active low, reorder to {btn2, btn1, up, down, left, right}
  // io[7:6] are spare pins and not part of the db9 port
  assign db9_atari = {~io[5], ~io[0], ~io[2], ~io[1], ~io[4], ~io[3]};
  // amiga mouse swaps two of the quadrature lines
  assign db9_amiga = {~io[5], ~io[0], ~io[3], ~io[1], ~io[4], ~io[2]};

  // a db9 mouse replaces the usb one since mice hold some lines active
  always_comb begin
    case (port_mouse)
      port_usb:       joy0 = hid_mouse;
      port_db9_atari: joy0 = db9_atari;
      port_db9_amiga: joy0 = db9_amiga;
      default:        joy0 = '0;        // port disabled
    endcase
  end

  // db9 is a joystick only while the mouse comes over usb
  assign db9_joy = (port_mouse == port_usb) ? db9_atari : '0;

  // joysticks are simply or'ed, both can be used at once
  assign joy1 = hid_joy[joy1_w-1:0] | db9_joy[joy1_w-1:0];

  // every selected row pulls its pressed keys low
  always_comb begin
    kbd_matrix_in = '1;                 // nothing selected reads all ones
    for (int r = 0; r < kbd_rows; r++) begin
      if (!kbd_matrix_out[r]) begin
        kbd_matrix_in = kbd_matrix_in & keyboard[r];
      end
    end
  end

endmodule

// File: rtl/audio_scaler.sv
`timescale 1ns/1ps

module audio_scaler (
  input  st_glue_pkg::volume_t                volume,
  input  logic [st_glue_pkg::audio_in_w-1:0]  audio_in_l,  // signed chipset mix
  input  logic [st_glue_pkg::audio_in_w-1:0]  audio_in_r,
  output logic [st_glue_pkg::audio_w-1:0]     audio_l,
  output logic [st_glue_pkg::audio_w-1:0]     audio_r
);
  import st_glue_pkg::*;

  // one channel: widen to 16 bits, then divide by a power of two
  function automatic logic [audio_w-1:0] scale(input logic [audio_in_w-1:0] smp,
                                               input volume_t vol);
    logic signed [audio_w-1:0] ext;
    ext = signed'({{(audio_w - audio_in_w){smp[audio_in_w-1]}}, smp}); // sign extend
    case (vol)
      vol_mute:    scale = '0;
      vol_quarter: scale = ext >>> 2;   // arithmetic, keeps the sign
      vol_half:    scale = ext >>> 1;
      default:     scale = ext;         // full volume
    endcase
  endfunction

  assign audio_l = scale(audio_in_l, volume);
  assign audio_r = scale(audio_in_r, volume);

endmodule

// File: rtl/st_glue.sv
`timescale 1ns/1ps

module st_glue #(
  parameter int unsigned wait_cycles = st_glue_pkg::sd_wait_cycles
) (
  input  logic                                    clk32,
  input  logic                                    rst_n,

  // boot and reset control
  input  logic                                    btn_reset,      // user button
  input  logic                                    sys_reset_req,  // reset from osd
  input  logic                                    coldboot,       // osd coldboot flag
  input  logic                                    ram_ready,      // sdram init done
  input  logic                                    flash_ready,
  input  logic [st_glue_pkg::img_size_w-1:0]      img_size,
  input  st_glue_pkg::chipset_t                   chipset,
  input  logic                                    tos_slot,
  output logic                                    st_resb,

  // rom into flash
  input  logic [st_glue_pkg::rom_low_w:1]         rom_addr,
  output logic [st_glue_pkg::flash_addr_w-1:0]    rom_flash_addr,

  // chipset ram into sdram
  input  logic [st_glue_pkg::ram_addr_w:1]        ram_addr,
  input  logic                                    ram_ras_n,
  output logic [st_glue_pkg::ram_word_w:1]        ram_word,
  output logic                                    ram_cs,

  // hid and db9 inputs
  input  logic [st_glue_pkg::io_w-1:0]            io,
  input  st_glue_pkg::mouse_port_t                port_mouse,
  input  logic [st_glue_pkg::mouse_w-1:0]         hid_mouse,
  input  logic [st_glue_pkg::hid_joy_w-1:0]       hid_joy,
  input  st_glue_pkg::kbd_matrix_t                keyboard,
  input  logic [st_glue_pkg::kbd_rows-1:0]        kbd_matrix_out,
  output logic [st_glue_pkg::mouse_w-1:0]         joy0,
  output logic [st_glue_pkg::joy1_w-1:0]          joy1,
  output logic [st_glue_pkg::mouse_w-1:0]         db9_joy,        // also reported to mcu
  output logic [st_glue_pkg::kbd_cols-1:0]        kbd_matrix_in,

  // audio
  input  st_glue_pkg::volume_t                    volume,
  input  logic [st_glue_pkg::audio_in_w-1:0]      audio_in_l,
  input  logic [st_glue_pkg::audio_in_w-1:0]      audio_in_r,
  output logic [st_glue_pkg::audio_w-1:0]         audio_l,
  output logic [st_glue_pkg::audio_w-1:0]         audio_r,

  // floppy and acsi towards the sd card controller
  input  logic [st_glue_pkg::sd_drives-1:0]       fdc_rd,
  input  logic [st_glue_pkg::sd_drives-1:0]       fdc_wr,
  input  logic [st_glue_pkg::lba_w-1:0]           fdc_lba,
  input  logic [st_glue_pkg::sd_byte_w-1:0]       fdc_wr_byte,
  input  logic [st_glue_pkg::sd_drives-1:0]       acsi_rd,
  input  logic [st_glue_pkg::sd_drives-1:0]       acsi_wr,
  input  logic [st_glue_pkg::lba_w-1:0]           acsi_lba,
  input  logic [st_glue_pkg::sd_byte_w-1:0]       acsi_wr_byte,
  output logic [2*st_glue_pkg::sd_drives-1:0]     sd_rstart,
  output logic [2*st_glue_pkg::sd_drives-1:0]     sd_wstart,
  output logic [st_glue_pkg::lba_w-1:0]           sd_sector,
  output logic [st_glue_pkg::sd_byte_w-1:0]       sd_inbyte
);

  // boot gate, ram scrambling, rom mapping
  sys_control #(
    .wait_cycles(wait_cycles)
  ) sys_control_i (
    .clk32          (clk32),
    .rst_n          (rst_n),
    .btn_reset      (btn_reset),
    .sys_reset_req  (sys_reset_req),
    .coldboot       (coldboot),
    .ram_ready      (ram_ready),
    .flash_ready    (flash_ready),
    .img_size       (img_size),
    .chipset        (chipset),
    .tos_slot       (tos_slot),
    .rom_addr       (rom_addr),
    .ram_addr       (ram_addr),
    .ram_ras_n      (ram_ras_n),
    .st_resb        (st_resb),
    .ram_word       (ram_word),
    .ram_cs         (ram_cs),
    .rom_flash_addr (rom_flash_addr)
  );

  input_mux input_mux_i (
    .io             (io),
    .port_mouse     (port_mouse),
    .hid_mouse      (hid_mouse),
    .hid_joy        (hid_joy),
    .keyboard       (keyboard),
    .kbd_matrix_out (kbd_matrix_out),
    .joy0           (joy0),
    .joy1           (joy1),
    .db9_joy        (db9_joy),
    .kbd_matrix_in  (kbd_matrix_in)
  );

  audio_scaler audio_scaler_i (
    .volume     (volume),
    .audio_in_l (audio_in_l),
    .audio_in_r (audio_in_r),
    .audio_l    (audio_l),
    .audio_r    (audio_r)
  );

  // floppy and acsi share one sd card
  sd_req_router sd_req_router_i (
    .clk32        (clk32),
    .rst_n        (rst_n),
    .fdc_rd       (fdc_rd),
    .fdc_wr       (fdc_wr),
    .fdc_lba      (fdc_lba),
    .fdc_wr_byte  (fdc_wr_byte),
    .acsi_rd      (acsi_rd),
    .acsi_wr      (acsi_wr),
    .acsi_lba     (acsi_lba),
    .acsi_wr_byte (acsi_wr_byte),
    .sd_rstart    (sd_rstart),
    .sd_wstart    (sd_wstart),
    .sd_sector    (sd_sector),
    .sd_inbyte    (sd_inbyte)
  );

endmodule

// File: sim/tb_st_glue.sv
`timescale 1ns/1ps

module tb_st_glue;
  import st_glue_pkg::*;

  localparam int tb_wait     = 200;                     // short boot timeout for simulation
  localparam int n_rand      = 300;                     // random cycles per test
  localparam int boot_cycles = 2 * 6 + tb_wait + 3 + 60;
  localparam int watchdog_ns = (boot_cycles + 5 * n_rand + tb_wait + 1000) * 8;

  logic                        clk32 = 1'b0;
  logic                        rst_n;
  logic                        btn_reset, sys_reset_req, coldboot, ram_ready, flash_ready;
  logic [img_size_w-1:0]       img_size;
  chipset_t                    chipset;
  logic                        tos_slot;
  logic                        st_resb;
  logic [rom_low_w:1]          rom_addr;
  logic [flash_addr_w-1:0]     rom_flash_addr;
  logic [ram_addr_w:1]         ram_addr;
  logic                        ram_ras_n;
  logic [ram_word_w:1]         ram_word;
  logic                        ram_cs;
  logic [io_w-1:0]             io;
  mouse_port_t                 port_mouse;
  logic [mouse_w-1:0]          hid_mouse, joy0, db9_joy;
  logic [hid_joy_w-1:0]        hid_joy;
  kbd_matrix_t                 keyboard;
  logic [kbd_rows-1:0]         kbd_matrix_out;
  logic [joy1_w-1:0]           joy1;
  logic [kbd_cols-1:0]         kbd_matrix_in;
  volume_t                     volume;
  logic [audio_in_w-1:0]       audio_in_l, audio_in_r;
  logic [audio_w-1:0]          audio_l, audio_r;
  logic [sd_drives-1:0]        fdc_rd, fdc_wr, acsi_rd, acsi_wr;
  logic [lba_w-1:0]            fdc_lba, acsi_lba, sd_sector;
  logic [sd_byte_w-1:0]        fdc_wr_byte, acsi_wr_byte, sd_inbyte;
  logic [2*sd_drives-1:0]      sd_rstart, sd_wstart;

  int seed;
  int check_count;
  int err_count;
  int chk_mark;                                         // counts at the start of a test
  int err_mark;

  // reference model state
  logic [scramble_w-1:0]       scr_m;                   // coldboot edges seen, mod 4
  logic                        cb_prev;
  sd_owner_t                   owner_m;

  st_glue #(.wait_cycles(tb_wait)) dut_i (.*);

  always #4 clk32 = ~clk32;                             // 8 ns period

  initial begin
    #(watchdog_ns);
    $display("watchdog expired after %0d ns, the run hung", watchdog_ns);
    $display("Simulation failed");
    $finish;
  end

  task automatic check_val(input string name, input logic [127:0] got,
                           input logic [127:0] exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("ERROR at %0t: %s is %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic finish_test(input string name);
    $display("test %s done: %0d checks, %0d errors", name,
             check_count - chk_mark, err_count - err_mark);
    chk_mark = check_count;
    err_mark = err_count;
  endtask

  // called right after a rising edge, dut sees 5 low edges
  task automatic apply_reset();
    rst_n <= 1'b0;
    repeat (5) @(posedge clk32);
    rst_n <= 1'b1;
  endtask

  // db9 pins are active low; amiga swaps the two quadrature lines on bits 3 and 0
  function automatic logic [mouse_w-1:0] db9_map(input logic [io_w-1:0] pins,
                                                 input logic amiga);
    logic [mouse_w-1:0] m;
    m[5] = ~pins[5];                                    // button 2
    m[4] = ~pins[0];                                    // button 1
    m[3] = amiga ? ~pins[3] : ~pins[2];
    m[2] = ~pins[1];
    m[1] = ~pins[4];
    m[0] = amiga ? ~pins[2] : ~pins[3];
    return m;
  endfunction

  // a column reads low if any driven row has a pressed key there
  function automatic logic [kbd_cols-1:0] kbd_columns(input kbd_matrix_t k,
                                                      input logic [kbd_rows-1:0] sel);
    logic [kbd_cols-1:0] col;
    int c;
    int r;
    col = '1;
    for (c = 0; c < kbd_cols; c++) begin
      for (r = 0; r < kbd_rows; r++) begin
        if (!sel[r] && !k[r][c]) col[c] = 1'b0;
      end
    end
    return col;
  endfunction

  function automatic logic [audio_w-1:0] expect_audio(input logic [audio_in_w-1:0] smp,
                                                      input volume_t vol);
    int v;
    v = int'(smp);
    if (smp[audio_in_w-1]) v = v - (1 << audio_in_w);   // two's complement value
    case (vol)
      vol_mute:    v = 0;
      vol_quarter: v = v >>> 2;
      vol_half:    v = v >>> 1;
      default:     ;
    endcase
    return v[audio_w-1:0];
  endfunction

  task automatic boot_sequence();
    logic [3:0] r;
    int i;
    apply_reset();                                      // no image, everything else ready
    repeat (tb_wait) begin
      @(posedge clk32);
      @(negedge clk32);
      check_val("st_resb", 128'(st_resb), 128'(0));
    end
    i = 0;
    while (i < 3 && st_resb !== 1'b1) begin             // timeout lands within a few edges
      @(posedge clk32);
      @(negedge clk32);
      i++;
    end
    check_val("st_resb", 128'(st_resb), 128'(1));
    @(posedge clk32);
    img_size <= '0;
    apply_reset();
    repeat (2) begin
      @(posedge clk32);
      @(negedge clk32);
      check_val("st_resb", 128'(st_resb), 128'(0));
    end
    @(posedge clk32);
    img_size <= {32'($random(seed)), 32'($random(seed))} | 64'd1;
    @(negedge clk32);
    check_val("st_resb", 128'(st_resb), 128'(0));      // not sampled yet
    @(posedge clk32);
    @(negedge clk32);
    check_val("st_resb", 128'(st_resb), 128'(1));
    repeat (50) begin                                   // reset sources act at once
      @(posedge clk32);
      r = 4'($random(seed));
      btn_reset     <= r[0] & r[1];
      sys_reset_req <= r[1] & r[2];
      ram_ready     <= r[2] | r[3];
      flash_ready   <= r[3] | r[0];
      @(negedge clk32);
      check_val("st_resb", 128'(st_resb),
                128'(ram_ready && flash_ready && !btn_reset && !sys_reset_req));
    end
    @(posedge clk32);
    btn_reset     <= 1'b0;
    sys_reset_req <= 1'b0;
    ram_ready     <= 1'b1;
    flash_ready   <= 1'b1;
    finish_test("boot gate");
  endtask

  task automatic coldboot_scramble();
    logic [ram_word_w:1] exp_word;
    scr_m   = '0;                                       // reset cleared the dut counter
    cb_prev = 1'b0;
    repeat (n_rand) begin
      @(posedge clk32);
      if (coldboot && !cb_prev) scr_m = scr_m + 2'd1;   // same edge the dut samples
      cb_prev = coldboot;
      coldboot  <= ($random(seed) % 4) == 0;
      ram_addr  <= 23'($random(seed));
      ram_ras_n <= 1'($random(seed));
      @(negedge clk32);
      exp_word      = ram_addr[ram_word_w:1];
      exp_word[4:3] = exp_word[4:3] ^ scr_m;
      check_val("ram_word", 128'(ram_word), 128'(exp_word));
      check_val("ram_cs", 128'(ram_cs), 128'(!ram_ras_n && !ram_addr[ram_addr_w]));
    end
    @(posedge clk32);
    coldboot <= 1'b0;
    finish_test("coldboot scramble");
  endtask

  task automatic rom_mapping();
    logic [flash_addr_w-1:0] exp_flash;
    int k;
    repeat (n_rand) begin
      @(posedge clk32);
      k = ($random(seed) & 32'h7fff_ffff) % 3;          // the three chipsets
      chipset  <= chipset_t'(k[1:0]);
      tos_slot <= 1'($random(seed));
      rom_addr <= 17'($random(seed));
      @(negedge clk32);
      exp_flash = 22'h08_0000 | (22'(tos_slot) << 18) |
                  (22'(chipset == chip_ste) << 17) | 22'(rom_addr);
      check_val("rom_flash_addr", 128'(rom_flash_addr), 128'(exp_flash));
    end
    finish_test("rom mapping");
  endtask

  task automatic input_mixing();
    kbd_matrix_t kb;
    logic [mouse_w-1:0] atari;
    logic [mouse_w-1:0] exp_joy0;
    logic [mouse_w-1:0] exp_db9;
    int row;
    repeat (n_rand) begin
      @(posedge clk32);
      for (row = 0; row < kbd_rows; row++) begin
        kb[row] = 8'($random(seed) | $random(seed));    // keys mostly released
      end
      keyboard       <= kb;
      kbd_matrix_out <= 15'($random(seed) | $random(seed)); // few rows driven
      io             <= 8'($random(seed));
      port_mouse     <= mouse_port_t'(2'($random(seed)));
      hid_mouse      <= 6'($random(seed));
      hid_joy        <= 8'($random(seed));
      @(negedge clk32);
      atari = db9_map(io, 1'b0);
      case (port_mouse)
        port_usb:       exp_joy0 = hid_mouse;
        port_db9_atari: exp_joy0 = atari;
        port_db9_amiga: exp_joy0 = db9_map(io, 1'b1);
        default:        exp_joy0 = '0;
      endcase
      exp_db9 = (port_mouse == port_usb) ? atari : '0;
      check_val("joy0", 128'(joy0), 128'(exp_joy0));
      check_val("db9_joy", 128'(db9_joy), 128'(exp_db9));
      check_val("joy1", 128'(joy1), 128'(hid_joy[joy1_w-1:0] | exp_db9[joy1_w-1:0]));
      check_val("kbd_matrix_in", 128'(kbd_matrix_in),
                128'(kbd_columns(keyboard, kbd_matrix_out)));
    end
    finish_test("input mixing");
  endtask

  task automatic audio_volume();
    int i;
    for (i = 0; i < n_rand; i++) begin
      @(posedge clk32);
      volume     <= volume_t'(2'(i));                   // walk all four steps
      audio_in_l <= 15'($random(seed));
      audio_in_r <= 15'($random(seed));
      @(negedge clk32);
      check_val("audio_l", 128'(audio_l), 128'(expect_audio(audio_in_l, volume)));
      check_val("audio_r", 128'(audio_r), 128'(expect_audio(audio_in_r, volume)));
    end
    finish_test("audio volume");
  endtask

  task automatic sd_routing();
    logic [15:0] r;
    sd_owner_t eff;
    owner_m = owner_floppy;                             // no request since reset
    repeat (n_rand) begin
      @(posedge clk32);
      if ((fdc_rd | fdc_wr) != '0) owner_m = owner_floppy;
      else if ((acsi_rd | acsi_wr) != '0) owner_m = owner_acsi;
      r = 16'($random(seed));
      fdc_rd       <= (r[1:0] == 2'd0) ? r[3:2] : 2'd0;   // sparse requests
      fdc_wr       <= (r[5:4] == 2'd0) ? r[7:6] : 2'd0;
      acsi_rd      <= (r[9:8] == 2'd0) ? r[11:10] : 2'd0;
      acsi_wr      <= (r[13:12] == 2'd0) ? r[15:14] : 2'd0;
      fdc_lba      <= $random(seed);
      acsi_lba     <= $random(seed);
      fdc_wr_byte  <= 8'($random(seed));
      acsi_wr_byte <= 8'($random(seed));
      @(negedge clk32);
      eff = ((acsi_rd | acsi_wr) != '0) ? owner_acsi : owner_m;
      check_val("sd_rstart", 128'(sd_rstart), 128'((4'(acsi_rd) << 2) | 4'(fdc_rd)));
      check_val("sd_wstart", 128'(sd_wstart), 128'((4'(acsi_wr) << 2) | 4'(fdc_wr)));
      check_val("sd_sector", 128'(sd_sector),
                128'((eff == owner_acsi) ? acsi_lba : fdc_lba));
      check_val("sd_inbyte", 128'(sd_inbyte),
                128'((eff == owner_acsi) ? acsi_wr_byte : fdc_wr_byte));
    end
    finish_test("sd routing");
  endtask

  initial begin
    seed           = 47415;
    check_count    = 0;
    err_count      = 0;
    chk_mark       = 0;
    err_mark       = 0;
    rst_n          <= 1'b0;
    btn_reset      <= 1'b0;
    sys_reset_req  <= 1'b0;
    coldboot       <= 1'b0;
    ram_ready      <= 1'b1;
    flash_ready    <= 1'b1;
    img_size       <= '0;
    chipset        <= chip_st;
    tos_slot       <= 1'b0;
    rom_addr       <= '0;
    ram_addr       <= '0;
    ram_ras_n      <= 1'b1;
    io             <= '1;                               // pins idle high
    port_mouse     <= port_usb;
    hid_mouse      <= '0;
    hid_joy        <= '0;
    keyboard       <= '1;
    kbd_matrix_out <= '1;
    volume         <= vol_full;
    audio_in_l     <= '0;
    audio_in_r     <= '0;
    fdc_rd         <= '0;
    fdc_wr         <= '0;
    fdc_lba        <= '0;
    fdc_wr_byte    <= '0;
    acsi_rd        <= '0;
    acsi_wr        <= '0;
    acsi_lba       <= '0;
    acsi_wr_byte   <= '0;
    boot_sequence();
    coldboot_scramble();
    rom_mapping();
    input_mixing();
    audio_volume();
    sd_routing();
    $display("all tests done: %0d checks, %0d errors", check_count, err_count);
    if (err_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: compile.f
common/st_glue_pkg.sv
sys_control/sys_control.sv
sd_req_router/sd_req_router.sv
rtl/input_mux.sv
rtl/audio_scaler.sv
rtl/st_glue.sv
sim/tb_st_glue.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the st_glue testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
  -f compile.f \
  --top-module tb_st_glue \
  -o sim_st_glue

out=$(./obj_dir/sim_st_glue)
echo "$out"

if grep -qx "Simulation passed" <<< "$out"; then
  exit 0
else
  exit 1
fi
